//--- esaxi.f
src/esaxi_pkg.sv
src/esaxi_write_channel.sv
src/esaxi_write_request.sv
src/esaxi_read_channel.sv
src/esaxi_read_response.sv
src/esaxi.sv
test/tb_clock_gen.sv
test/esaxi_checker.sv
test/esaxi_properties.sv
test/tb_esaxi.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f esaxi.f --top-module tb_esaxi -o sim_esaxi

# the log decides pass or fail, so a nonzero exit of the run is not fatal here
./obj_dir/sim_esaxi +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
   echo "simulation ended without a verdict"
   exit 1
fi
exit 0

//--- src/esaxi.sv
module esaxi
   import esaxi_pkg::*;
(
   input  logic              s_axi_aclk,
   input  logic              s_axi_aresetn,
   // aw / w / b
   input  logic [addr_w-1:0] s_axi_awaddr,
   input  logic [1:0]        s_axi_awburst,
   input  logic [7:0]        s_axi_awlen,
   input  logic [2:0]        s_axi_awsize,
   input  logic              s_axi_awvalid,
   output logic              s_axi_awready,
   input  logic [data_w-1:0] s_axi_wdata,
   input  logic [3:0]        s_axi_wstrb,
   input  logic              s_axi_wlast,
   input  logic              s_axi_wvalid,
   output logic              s_axi_wready,
   output logic [1:0]        s_axi_bresp,
   output logic              s_axi_bvalid,
   input  logic              s_axi_bready,
   // ar / r
   input  logic [addr_w-1:0] s_axi_araddr,
   input  logic [1:0]        s_axi_arburst,
   input  logic [7:0]        s_axi_arlen,
   input  logic [2:0]        s_axi_arsize,
   input  logic              s_axi_arvalid,
   output logic              s_axi_arready,
   output logic [data_w-1:0] s_axi_rdata,
   output logic              s_axi_rlast,
   output logic [1:0]        s_axi_rresp,
   output logic              s_axi_rvalid,
   input  logic              s_axi_rready,
   // mesh
   output logic              txwr_access,
   output logic [pkt_w-1:0]  txwr_packet,
   input  logic              txwr_wait,
   output logic              txrd_access,
   output logic [pkt_w-1:0]  txrd_packet,
   input  logic              txrd_wait,     // not honoured, one read at a time
   input  logic              rxrr_access,
   input  logic [pkt_w-1:0]  rxrr_packet
);

   logic              wr_beat;
   logic [addr_w-1:0] wr_addr;
   logic [1:0]        wr_size;
   logic [1:0]        rd_size;

   esaxi_write_channel i_write_channel (
      .s_axi_aclk, .s_axi_aresetn, .s_axi_awaddr, .s_axi_awburst, .s_axi_awlen,
      .s_axi_awsize, .s_axi_awvalid, .s_axi_wvalid, .s_axi_wlast, .s_axi_bready,
      .txwr_wait, .s_axi_awready, .s_axi_wready, .s_axi_bresp, .s_axi_bvalid,
      .wr_beat, .wr_addr, .wr_size
   );

   esaxi_write_request i_write_request (
      .s_axi_aclk, .s_axi_aresetn, .wr_beat, .wr_addr, .wr_size,
      .s_axi_wdata, .s_axi_wstrb, .txwr_access, .txwr_packet
   );

   esaxi_read_channel i_read_channel (
      .s_axi_aclk, .s_axi_aresetn, .s_axi_araddr, .s_axi_arburst, .s_axi_arlen,
      .s_axi_arsize, .s_axi_arvalid, .s_axi_rready, .s_axi_rvalid,
      .s_axi_arready, .s_axi_rlast, .txrd_access, .txrd_packet, .rd_size
   );

   esaxi_read_response i_read_response (
      .s_axi_aclk, .s_axi_aresetn, .rxrr_access, .rxrr_packet, .rd_size,
      .s_axi_rready, .s_axi_rdata, .s_axi_rresp, .s_axi_rvalid
   );

endmodule

//--- src/esaxi_pkg.sv
package esaxi_pkg;

   // ######################################
   // widths and mesh identity
   // ######################################
   localparam int addr_w = 32;
   localparam int data_w = 32;
   localparam int pkt_w  = 104;   // access+write+mode+ctrl+3x32

   localparam logic [11:0]       node_id     = 12'h810;
   localparam logic [addr_w-1:0] return_addr = {node_id, 4'hE, 16'h0000};  // rr lands here

   // packet field positions, lsb first
   localparam int     data_lsb  = 40;      // after access/write/mode/ctrl/dstaddr
   localparam logic [3:0] ctrl_mode = 4'h0;  // no ctrlmode use on this port

   // ######################################
   // axi and mesh codes
   // ######################################
   localparam logic [1:0] burst_incr = 2'b01;  // fixed and wrap both step nothing
   localparam logic [1:0] resp_okay  = 2'b00;

   localparam logic [1:0] mode_byte = 2'd0;    // = axi size[1:0]
   localparam logic [1:0] mode_half = 2'd1;
   localparam logic [1:0] mode_word = 2'd2;

   // build one mesh packet
   function automatic logic [pkt_w-1:0] pack_emesh(
      input logic              access,
      input logic              write,
      input logic [1:0]        datamode,
      input logic [addr_w-1:0] dstaddr,
      input logic [data_w-1:0] data,
      input logic [addr_w-1:0] srcaddr
   );
      return {srcaddr, data, dstaddr, ctrl_mode, datamode, write, access};
   endfunction

   // data field only, the rest of a read response is not needed
   function automatic logic [data_w-1:0] unpack_data(input logic [pkt_w-1:0] packet);
      return packet[data_lsb +: data_w];
   endfunction

endpackage

//--- src/esaxi_read_channel.sv
module esaxi_read_channel
   import esaxi_pkg::*;
(
   input  logic              s_axi_aclk,
   input  logic              s_axi_aresetn,
   input  logic [addr_w-1:0] s_axi_araddr,
   input  logic [1:0]        s_axi_arburst,
   input  logic [7:0]        s_axi_arlen,
   input  logic [2:0]        s_axi_arsize,
   input  logic              s_axi_arvalid,
   input  logic              s_axi_rready,
   input  logic              s_axi_rvalid,   // from the response block
   output logic              s_axi_arready,
   output logic              s_axi_rlast,
   output logic              txrd_access,
   output logic [pkt_w-1:0]  txrd_packet,
   output logic [1:0]        rd_size
);

   logic              read_active;   // single read in flight
   logic              active_q;      // for the leading edge
   logic              rnext;         // non-last beat done, ask for the next
   logic [7:0]        beats_left;
   logic              rd_incr;
   logic [addr_w-1:0] rd_addr;
   logic [addr_w-1:0] req_addr;
   logic [1:0]        req_mode;
   logic              r_hs;
   logic              last_rd;

   assign r_hs    = s_axi_rvalid & s_axi_rready;
   assign last_rd = r_hs & s_axi_rlast;

   // ######################################
   // ar handshake and beat count
   // ######################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_arready <= 1'b0;
         read_active   <= 1'b0;
         beats_left    <= 8'd0;
         s_axi_rlast   <= 1'b0;
      end
      else
      begin
         if (!s_axi_arready && !read_active)
            s_axi_arready <= 1'b1;
         else if (s_axi_arvalid)
            s_axi_arready <= 1'b0;

         if (s_axi_arready && s_axi_arvalid)
         begin
            read_active <= 1'b1;
            beats_left  <= s_axi_arlen;
            s_axi_rlast <= (s_axi_arlen == 8'd0);   // single beat
         end
         else
         begin
            if (last_rd)
               read_active <= 1'b0;
            if (r_hs)
            begin
               beats_left <= beats_left - 8'd1;
               if (beats_left == 8'd1)
                  s_axi_rlast <= 1'b1;   // one beat to go
            end
         end
      end
   end

   // address and size, stepped with the captured burst type
   always_ff @(posedge s_axi_aclk)
   begin
      if (s_axi_arready && s_axi_arvalid)
      begin
         rd_addr <= s_axi_araddr;
         rd_size <= s_axi_arsize[1:0];
         rd_incr <= (s_axi_arburst == burst_incr);
      end
      else if (r_hs && rd_incr)
      begin
         rd_addr[addr_w-1:2] <= rd_addr[addr_w-1:2] + 1'b1;
         rd_addr[1:0]        <= 2'b00;
      end
   end

   // ######################################
   // request issue, one per beat
   // ######################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         active_q    <= 1'b0;
         rnext       <= 1'b0;
         txrd_access <= 1'b0;
      end
      else
      begin
         active_q    <= read_active;
         rnext       <= r_hs & ~s_axi_rlast;
         txrd_access <= (read_active & ~active_q) | rnext;   // first beat or next
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      req_addr <= rd_addr;
      req_mode <= rd_size;
   end

   assign txrd_packet = pack_emesh(txrd_access, 1'b0, req_mode, req_addr,
                                   {data_w{1'b0}}, return_addr);

endmodule

//--- src/esaxi_read_response.sv
module esaxi_read_response
   import esaxi_pkg::*;
(
   input  logic              s_axi_aclk,
   input  logic              s_axi_aresetn,
   input  logic              rxrr_access,
   input  logic [pkt_w-1:0]  rxrr_packet,
   input  logic [1:0]        rd_size,
   input  logic              s_axi_rready,
   output logic [data_w-1:0] s_axi_rdata,
   output logic [1:0]        s_axi_rresp,
   output logic              s_axi_rvalid
);

   logic [data_w-1:0] rr_data;

   assign rr_data     = unpack_data(rxrr_packet);
   assign s_axi_rresp = resp_okay;

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         s_axi_rvalid <= 1'b0;
      else if (rxrr_access)
         s_axi_rvalid <= 1'b1;
      else if (s_axi_rready)
         s_axi_rvalid <= 1'b0;   // hold while rready low
   end

   // data fills every lane the master might read
   always_ff @(posedge s_axi_aclk)
   begin
      if (rxrr_access)
      begin
         case (rd_size)
            mode_byte: s_axi_rdata <= {4{rr_data[7:0]}};
            mode_half: s_axi_rdata <= {2{rr_data[15:0]}};
            default:   s_axi_rdata <= rr_data;   // word
         endcase
      end
   end

endmodule

//--- src/esaxi_write_channel.sv
module esaxi_write_channel
   import esaxi_pkg::*;
(
   input  logic              s_axi_aclk,
   input  logic              s_axi_aresetn,
   input  logic [addr_w-1:0] s_axi_awaddr,
   input  logic [1:0]        s_axi_awburst,
   input  logic [7:0]        s_axi_awlen,
   input  logic [2:0]        s_axi_awsize,
   input  logic              s_axi_awvalid,
   input  logic              s_axi_wvalid,
   input  logic              s_axi_wlast,
   input  logic              s_axi_bready,
   input  logic              txwr_wait,
   output logic              s_axi_awready,
   output logic              s_axi_wready,
   output logic [1:0]        s_axi_bresp,
   output logic              s_axi_bvalid,
   output logic              wr_beat,      // w transfer this cycle
   output logic [addr_w-1:0] wr_addr,      // address of the current beat
   output logic [1:0]        wr_size
);

   logic       write_active;   // aw accepted, last beat not yet seen
   logic [7:0] beats_left;     // beats after the current one
   logic       wr_incr;        // captured burst type
   logic       last_beat;

   assign wr_beat     = s_axi_wready & s_axi_wvalid;
   // wlast normally ends it, the counter guards a missing wlast
   assign last_beat   = wr_beat & (s_axi_wlast | (beats_left == 8'd0));
   assign s_axi_bresp = resp_okay;   // never an error

   // ######################################
   // handshake control
   // ######################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_awready <= 1'b0;
         s_axi_wready  <= 1'b0;
         s_axi_bvalid  <= 1'b0;
         write_active  <= 1'b0;
         beats_left    <= 8'd0;
      end
      else
      begin
         // ready again once idle and b is done
         if (!s_axi_awready && !write_active && !s_axi_bvalid)
            s_axi_awready <= 1'b1;
         else if (s_axi_awvalid)
            s_axi_awready <= 1'b0;

         if (s_axi_awready && s_axi_awvalid)
         begin
            write_active <= 1'b1;
            beats_left   <= s_axi_awlen;
         end
         else if (last_beat)
            write_active <= 1'b0;
         else if (wr_beat)
            beats_left <= beats_left - 8'd1;

         if (last_beat)
            s_axi_wready <= 1'b0;
         else if (write_active)
            s_axi_wready <= ~txwr_wait;   // one cycle behind the mesh wait

         if (last_beat)
            s_axi_bvalid <= 1'b1;
         else if (s_axi_bready)
            s_axi_bvalid <= 1'b0;         // held until bready
      end
   end

   // ######################################
   // address capture and step
   // ######################################
   always_ff @(posedge s_axi_aclk)
   begin
      if (s_axi_awready && s_axi_awvalid)
      begin
         wr_addr <= s_axi_awaddr;
         wr_size <= s_axi_awsize[1:0];   // 0 byte, 1 half, 2 word
         wr_incr <= (s_axi_awburst == burst_incr);
      end
      else if (wr_beat && wr_incr)
      begin
         wr_addr[addr_w-1:2] <= wr_addr[addr_w-1:2] + 1'b1;  // next word
         wr_addr[1:0]        <= 2'b00;                        // byte lanes cleared
      end
   end

endmodule

//--- src/esaxi_write_request.sv
module esaxi_write_request
   import esaxi_pkg::*;
(
   input  logic              s_axi_aclk,
   input  logic              s_axi_aresetn,
   input  logic              wr_beat,
   input  logic [addr_w-1:0] wr_addr,
   input  logic [1:0]        wr_size,
   input  logic [data_w-1:0] s_axi_wdata,
   input  logic [3:0]        s_axi_wstrb,
   output logic              txwr_access,
   output logic [pkt_w-1:0]  txwr_packet
);

   logic              pre_access;   // stage 1 valid
   logic [data_w-1:0] pre_data;
   logic [addr_w-1:0] pre_addr;
   logic [1:0]        pre_mode;
   logic [data_w-1:0] tx_data;
   logic [addr_w-1:0] tx_addr;
   logic [1:0]        tx_mode;

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         pre_access  <= 1'b0;
         txwr_access <= 1'b0;
      end
      else
      begin
         pre_access  <= wr_beat;
         txwr_access <= pre_access;   // 2 cycles after the beat
      end
   end

   // ######################################
   // stage 1, strobe alignment
   // ######################################
   always_ff @(posedge s_axi_aclk)
   begin
      pre_mode                <= wr_size;
      pre_addr[addr_w-1:2]    <= wr_addr[addr_w-1:2];
      if (s_axi_wstrb[0] || (wr_size == mode_word))
      begin
         pre_data      <= s_axi_wdata;              // no shift
         pre_addr[1:0] <= 2'd0;
      end
      else if (s_axi_wstrb[1])
      begin
         pre_data      <= {8'd0, s_axi_wdata[31:8]};
         pre_addr[1:0] <= 2'd1;
      end
      else if (s_axi_wstrb[2])
      begin
         pre_data      <= {16'd0, s_axi_wdata[31:16]};
         pre_addr[1:0] <= 2'd2;
      end
      else
      begin
         pre_data      <= {24'd0, s_axi_wdata[31:24]};  // lane 3 or no strobe
         pre_addr[1:0] <= 2'd3;
      end
   end

   // stage 2, plain register, both stages move every cycle
   always_ff @(posedge s_axi_aclk)
   begin
      tx_data <= pre_data;
      tx_addr <= pre_addr;
      tx_mode <= pre_mode;
   end

   assign txwr_packet = pack_emesh(txwr_access, 1'b1, tx_mode, tx_addr, tx_data,
                                   {addr_w{1'b0}});   // writes carry no source

endmodule

//--- test/esaxi_checker.sv
module esaxi_checker
   import esaxi_pkg::*;
(
   input  logic             clk,
   input  logic             resetn,
   // row stream from the testbench
   input  logic             row_valid,
   input  logic             row_op,      // 1 write, 0 read
   input  logic [31:0]      row_addr,
   input  logic [1:0]       row_burst,
   input  logic [7:0]       row_len,
   input  logic [2:0]       row_size,
   input  logic [3:0]       row_strb,
   input  logic [31:0]      row_data,
   // dut outputs watched
   input  logic             txwr_access,
   input  logic [pkt_w-1:0] txwr_packet,
   input  logic             txrd_access,
   input  logic [pkt_w-1:0] txrd_packet,
   input  logic             s_axi_rvalid,
   input  logic             s_axi_rready,
   input  logic [31:0]      s_axi_rdata,
   input  logic             s_axi_rlast,
   input  logic [1:0]       s_axi_rresp,
   input  logic             s_axi_bvalid,
   input  logic             s_axi_bready,
   input  logic [1:0]       s_axi_bresp,
   output int               error_count,
   output int               pending
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [31:0] wq_dst[$];    // expected write packets
   logic [31:0] wq_data[$];
   logic [1:0]  wq_mode[$];
   logic [31:0] rq_dst[$];    // expected read requests
   logic [1:0]  rq_mode[$];
   logic [31:0] rbeat_data[$];   // expected r beats
   logic        rbeat_last[$];
   int          b_expected;
   int          outstanding;     // read requests without an r handshake
   logic        hold_seen;
   logic [31:0] hold_data;

   initial
   begin
      error_count = 0;
      pending     = 0;
      b_expected  = 0;
      outstanding = 0;
      hold_seen   = 1'b0;
      hold_data   = 32'd0;
   end

   task automatic report_problem(input string what);
      $display("%s", what);
      error_count++;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERROR %s: got %h, expected %h", name, got, exp);
         error_count++;
      end
   endtask

   // ########################################
   // prediction from the row
   // ########################################
   always @(posedge clk)
   begin : predict
      logic [31:0] d;
      logic [31:0] shifted;
      logic [31:0] dst;
      logic [31:0] rr;
      logic [1:0]  lsb;
      logic [29:0] word;
      if (row_valid)
      begin
         for (int i = 0; i <= int'(row_len); i++)
         begin
            word = row_addr[31:2] + ((row_burst == 2'b01) ? 30'(i) : 30'd0);
            if (row_op)
            begin
               d = row_data + 32'(i) * 32'h01010101;
               if (row_size[1:0] == 2'd2 || row_strb[0])
               begin
                  lsb     = 2'd0;    // word or lane 0 stays unshifted
                  shifted = d;
               end
               else if (row_strb[1])
               begin
                  lsb     = 2'd1;
                  shifted = d >> 8;
               end
               else if (row_strb[2])
               begin
                  lsb     = 2'd2;
                  shifted = d >> 16;
               end
               else
               begin
                  lsb     = 2'd3;
                  shifted = d >> 24;
               end
               wq_dst.push_back({word, lsb});
               wq_data.push_back(shifted);
               wq_mode.push_back(row_size[1:0]);
            end
            else
            begin
               // first beat keeps araddr and incr beats are word aligned
               if (i == 0 || row_burst != 2'b01)
                  dst = row_addr;
               else
                  dst = {word, 2'b00};
               rq_dst.push_back(dst);
               rq_mode.push_back(row_size[1:0]);
               rr = dst ^ 32'hA5A5A5A5;   // responder rule
               case (row_size[1:0])
                  2'd0:    rbeat_data.push_back({4{rr[7:0]}});
                  2'd1:    rbeat_data.push_back({2{rr[15:0]}});
                  default: rbeat_data.push_back(rr);
               endcase
               rbeat_last.push_back(i == int'(row_len));
            end
         end
         if (row_op)
            b_expected++;
      end
   end

   // ########################################
   // compare
   // ########################################
   always @(posedge clk)
   begin : compare
      if (resetn)
      begin
         if (txwr_access)
         begin
            if (wq_dst.size() == 0)
               report_problem("write packet arrived with none expected");
            else
            begin
               check_value("txwr_packet.write", 32'(txwr_packet[1]), 32'd1);
               check_value("txwr_packet.datamode", 32'(txwr_packet[3:2]),
                           32'(wq_mode.pop_front()));
               check_value("txwr_packet.ctrlmode", 32'(txwr_packet[7:4]), 32'd0);
               check_value("txwr_packet.dstaddr", txwr_packet[39:8], wq_dst.pop_front());
               check_value("txwr_packet.data", txwr_packet[71:40], wq_data.pop_front());
               check_value("txwr_packet.srcaddr", txwr_packet[103:72], 32'd0);
            end
         end
         if (txrd_access)
         begin
            if (outstanding != 0)
               report_problem("read request issued before the previous beat completed");
            outstanding++;
            if (rq_dst.size() == 0)
               report_problem("read request arrived with none expected");
            else
            begin
               check_value("txrd_packet.write", 32'(txrd_packet[1]), 32'd0);
               check_value("txrd_packet.datamode", 32'(txrd_packet[3:2]),
                           32'(rq_mode.pop_front()));
               check_value("txrd_packet.ctrlmode", 32'(txrd_packet[7:4]), 32'd0);
               check_value("txrd_packet.dstaddr", txrd_packet[39:8], rq_dst.pop_front());
               check_value("txrd_packet.data", txrd_packet[71:40], 32'd0);
               check_value("txrd_packet.srcaddr", txrd_packet[103:72], 32'h810E0000);
            end
         end
         // rdata must sit still while the master stalls
         if (hold_seen && s_axi_rvalid)
            check_value("s_axi_rdata (held)", s_axi_rdata, hold_data);
         hold_seen = s_axi_rvalid && !s_axi_rready;
         hold_data = s_axi_rdata;
         if (s_axi_rvalid && s_axi_rready)
         begin
            outstanding--;
            if (rbeat_data.size() == 0)
               report_problem("r beat arrived with none expected");
            else
            begin
               check_value("s_axi_rdata", s_axi_rdata, rbeat_data.pop_front());
               check_value("s_axi_rlast", 32'(s_axi_rlast), 32'(rbeat_last.pop_front()));
               check_value("s_axi_rresp", 32'(s_axi_rresp), 32'd0);
            end
         end
         if (s_axi_bvalid && s_axi_bready)
         begin
            if (b_expected == 0)
               report_problem("write response arrived with none expected");
            else
               b_expected--;
            check_value("s_axi_bresp", 32'(s_axi_bresp), 32'd0);
         end
      end
      pending = wq_dst.size() + rq_dst.size() + rbeat_data.size() + b_expected;
   end

endmodule

//--- test/esaxi_properties.sv
module esaxi_properties (
   input logic s_axi_aclk,
   input logic s_axi_aresetn,
   input logic s_axi_bvalid,
   input logic s_axi_bready,
   input logic s_axi_rvalid,
   input logic s_axi_rready,
   input logic txwr_access,
   input logic txrd_access
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;   // read by the top at the end

   b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
      else begin fail_cnt++; $error("bvalid dropped before bready"); end

   r_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid)
      else begin fail_cnt++; $error("rvalid dropped before rready"); end

   // one request per beat, never back to back
   rd_gap: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      txrd_access |=> !txrd_access)
      else begin fail_cnt++; $error("txrd_access in two consecutive cycles"); end

   quiet_start: assert property (@(posedge s_axi_aclk)
      $rose(s_axi_aresetn) |-> !txwr_access && !txrd_access && !s_axi_bvalid && !s_axi_rvalid)
      else begin fail_cnt++; $error("strobe high right after reset"); end

endmodule

bind esaxi esaxi_properties i_props (.*);

//--- test/tb_clock_gen.sv
module tb_clock_gen (
   output logic clk,
   output logic resetn
);
   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   initial
   begin
      resetn = 1'b0;
      repeat (5) @(posedge clk);
      resetn <= 1'b1;   // released after 5 cycles
   end

endmodule

//--- test/tb_esaxi.sv
module tb_esaxi;
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct packed {
      logic        op;      // 1 write, 0 read
      logic [31:0] addr;
      logic [1:0]  burst;
      logic [7:0]  len;
      logic [2:0]  size;
      logic [3:0]  strb;
      logic [31:0] data;    // base value plus 01010101 per beat
   } row_t;

   localparam int n_rows = 10;

   row_t        rows [n_rows];
   row_t        cur;
   logic        row_valid;
   integer      seed = 94373;

   logic s_axi_aclk, s_axi_aresetn;
   logic [31:0] s_axi_awaddr, s_axi_wdata, s_axi_araddr, s_axi_rdata;
   logic [1:0]  s_axi_awburst, s_axi_arburst, s_axi_bresp, s_axi_rresp;
   logic [7:0]  s_axi_awlen, s_axi_arlen;
   logic [2:0]  s_axi_awsize, s_axi_arsize;
   logic [3:0]  s_axi_wstrb;
   logic s_axi_awvalid, s_axi_awready, s_axi_wlast, s_axi_wvalid, s_axi_wready;
   logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
   logic s_axi_rlast, s_axi_rvalid, s_axi_rready;
   logic txwr_access, txwr_wait, txrd_access, txrd_wait, rxrr_access;
   logic [103:0] txwr_packet, txrd_packet, rxrr_packet;
   int error_count, pending;

   tb_clock_gen i_clock_gen (.clk(s_axi_aclk), .resetn(s_axi_aresetn));

   esaxi i_esaxi (.*);

   esaxi_checker i_checker (
      .clk(s_axi_aclk), .resetn(s_axi_aresetn), .row_valid,
      .row_op(cur.op), .row_addr(cur.addr), .row_burst(cur.burst), .row_len(cur.len),
      .row_size(cur.size), .row_strb(cur.strb), .row_data(cur.data),
      .txwr_access, .txwr_packet, .txrd_access, .txrd_packet, .s_axi_rvalid,
      .s_axi_rready, .s_axi_rdata, .s_axi_rlast, .s_axi_rresp, .s_axi_bvalid,
      .s_axi_bready, .s_axi_bresp, .error_count, .pending
   );

   // ########################################
   // stimulus table
   // ########################################
   initial
   begin
      rows[0] = '{1'b1, 32'h0000_0100, 2'b01, 8'd0, 3'd2, 4'hF, 32'h1122_3344};
      rows[1] = '{1'b1, 32'h0000_0205, 2'b01, 8'd0, 3'd0, 4'h2, 32'hAABB_CCDD};
      rows[2] = '{1'b1, 32'h0000_0206, 2'b01, 8'd0, 3'd0, 4'h4, 32'hAABB_CCDD};
      rows[3] = '{1'b1, 32'h0000_0207, 2'b01, 8'd0, 3'd0, 4'h8, 32'hAABB_CCDD};
      rows[4] = '{1'b1, 32'h0000_0300, 2'b01, 8'd3, 3'd2, 4'hF, 32'h0102_0304};
      rows[5] = '{1'b1, 32'h0000_0400, 2'b00, 8'd3, 3'd2, 4'hF, 32'h5060_7080};  // fixed
      rows[6] = '{1'b0, 32'h0000_0500, 2'b01, 8'd0, 3'd2, 4'h0, 32'h0};
      rows[7] = '{1'b0, 32'h0000_0600, 2'b01, 8'd3, 3'd2, 4'h0, 32'h0};
      rows[8] = '{1'b0, 32'h0000_0703, 2'b00, 8'd0, 3'd0, 4'h0, 32'h0};  // byte
      rows[9] = '{1'b0, 32'h0000_0802, 2'b01, 8'd1, 3'd1, 4'h0, 32'h0};  // half
   end

   task automatic write_burst(input row_t r);
      s_axi_awaddr  <= r.addr;
      s_axi_awburst <= r.burst;
      s_axi_awlen   <= r.len;
      s_axi_awsize  <= r.size;
      s_axi_awvalid <= 1'b1;
      @(posedge s_axi_aclk);
      while (!s_axi_awready) @(posedge s_axi_aclk);
      s_axi_awvalid <= 1'b0;
      for (int i = 0; i <= int'(r.len); i++)
      begin
         s_axi_wdata  <= r.data + 32'(i) * 32'h0101_0101;
         s_axi_wstrb  <= r.strb;
         s_axi_wlast  <= (i == int'(r.len));
         s_axi_wvalid <= 1'b1;
         @(posedge s_axi_aclk);
         while (!s_axi_wready) @(posedge s_axi_aclk);   // hold until accepted
      end
      s_axi_wvalid <= 1'b0;
      s_axi_wlast  <= 1'b0;
      @(posedge s_axi_aclk);
      while (!(s_axi_bvalid && s_axi_bready)) @(posedge s_axi_aclk);
   endtask

   task automatic read_burst(input row_t r);
      s_axi_araddr  <= r.addr;
      s_axi_arburst <= r.burst;
      s_axi_arlen   <= r.len;
      s_axi_arsize  <= r.size;
      s_axi_arvalid <= 1'b1;
      @(posedge s_axi_aclk);
      while (!s_axi_arready) @(posedge s_axi_aclk);
      s_axi_arvalid <= 1'b0;
      @(posedge s_axi_aclk);
      while (!(s_axi_rvalid && s_axi_rready && s_axi_rlast)) @(posedge s_axi_aclk);
   endtask

   initial
   begin : main
      int total;
      s_axi_awaddr  = 0;
      s_axi_awburst = 0;
      s_axi_awlen   = 0;
      s_axi_awsize  = 0;
      s_axi_awvalid = 0;
      s_axi_wdata   = 0;
      s_axi_wstrb   = 0;
      s_axi_wlast   = 0;
      s_axi_wvalid  = 0;
      s_axi_araddr  = 0;
      s_axi_arburst = 0;
      s_axi_arlen   = 0;
      s_axi_arsize  = 0;
      s_axi_arvalid = 0;
      txrd_wait     = 0;   // txrd_wait stays low
      row_valid = 0;
      cur = '0;
      @(posedge s_axi_aresetn);
      @(posedge s_axi_aclk);
      for (int r = 0; r < n_rows; r++)
      begin
         cur       <= rows[r];
         row_valid <= 1'b1;   // checker predicts from this
         @(posedge s_axi_aclk);
         row_valid <= 1'b0;
         if (rows[r].op)
            write_burst(rows[r]);
         else
            read_burst(rows[r]);
      end
      repeat (10) @(posedge s_axi_aclk);
      total = error_count + i_esaxi.i_props.fail_cnt + pending;
      $display("errors: %0d checker, %0d assertion, %0d expected items never seen",
               error_count, i_esaxi.i_props.fail_cnt, pending);
      if (total == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

   // ########################################
   // random ready and mesh side
   // ########################################
   initial
   begin : ready_toggle
      int rnd;
      s_axi_rready = 1'b0;
      s_axi_bready = 1'b0;
      forever
      begin
         @(posedge s_axi_aclk);
         rnd = $random(seed);
         s_axi_rready <= rnd[0];
         s_axi_bready <= rnd[1];
      end
   end

   initial
   begin : wait_pulse
      int rnd;
      txwr_wait = 1'b0;
      forever
      begin
         @(posedge s_axi_aclk);
         if (txwr_access)
         begin
            rnd = $random(seed);
            if (rnd[0])   // about half the packets stall the port
            begin
               txwr_wait <= 1'b1;
               repeat (1 + rnd[2:1]) @(posedge s_axi_aclk);
               txwr_wait <= 1'b0;
            end
         end
      end
   end

   // answers each read request after 1 to 4 cycles
   initial
   begin : responder
      int          rnd;
      logic [31:0] dst;
      rxrr_access = 1'b0;
      rxrr_packet = '0;
      forever
      begin
         @(posedge s_axi_aclk);
         if (txrd_access)
         begin
            dst = txrd_packet[39:8];
            rnd = $random(seed);
            repeat (1 + rnd[1:0]) @(posedge s_axi_aclk);
            rxrr_packet <= {32'd0, dst ^ 32'hA5A5_A5A5, dst, 4'h0, 2'd2, 1'b1, 1'b1};
            rxrr_access <= 1'b1;
            @(posedge s_axi_aclk);
            rxrr_access <= 1'b0;
         end
      end
   end

   initial
   begin : watchdog
      int limit;
      @(posedge s_axi_aresetn);
      limit = 100;
      for (int r = 0; r < n_rows; r++)
         limit += (int'(rows[r].len) + 1) * 40;   // per beat budget
      repeat (limit) @(posedge s_axi_aclk);
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
   end

endmodule
